//--- tb.f
common/gmii_pkg.sv
common/tx_frame_if.sv
frame_queue/frame_queue.sv
source/tx_arbiter.sv
source/gmii_tx_framer.sv
source/gmii_tx_top.sv
testbench/gmii_tx_checker.sv
testbench/tb_gmii_tx.sv

//--- Bender.yml
package:
  name: gmii_tx

sources:
  - common/gmii_pkg.sv
  - common/tx_frame_if.sv
  - frame_queue/frame_queue.sv
  - source/tx_arbiter.sv
  - source/gmii_tx_framer.sv
  - source/gmii_tx_top.sv
  - target: test
    files:
      - testbench/gmii_tx_checker.sv
      - testbench/tb_gmii_tx.sv

//--- testbench/tb_gmii_tx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_gmii_tx;

   localparam int NUM_SRC     = 2;
   localparam int QUEUE_DEPTH = 64;
   localparam int NUM_TESTS   = 8;
   localparam int FRAME_OVH   = 8 + gmii_pkg::IFG_LEN + 4;   // Preamble, SFD, gap, slack

   // Test table: name, sources to load, payload length per source, sends in one cycle
   string              test_name  [NUM_TESTS] = '{"single_src0", "single_src1", "both_sim_a",
                                                  "min_len_src0", "both_sim_b", "empty_send",
                                                  "empty_and_one", "full_depth"};
   logic [NUM_SRC-1:0] load_mask  [NUM_TESTS] = '{2'b01, 2'b10, 2'b11, 2'b01,
                                                  2'b11, 2'b11, 2'b11, 2'b11};
   int                 lens       [NUM_TESTS][NUM_SRC] = '{'{5, 0}, '{0, 9}, '{6, 4}, '{1, 0},
                                                           '{3, 7}, '{0, 0}, '{0, 2},
                                                           '{QUEUE_DEPTH, QUEUE_DEPTH}};
   bit                 same_cycle [NUM_TESTS] = '{1, 1, 1, 1, 1, 1, 0, 0};

   logic                 GMII_GTX_CLK_int;
   logic                 rst_n_i;
   logic [NUM_SRC-1:0]   src_wr_en_i;
   gmii_pkg::gmii_byte_t src_wr_data_i;
   logic [NUM_SRC-1:0]   src_send_i;
   logic [NUM_SRC-1:0]   src_busy_o;
   gmii_pkg::gmii_byte_t gmii_txd_o;
   logic                 gmii_tx_en_o;
   gmii_pkg::gmii_byte_t payload [NUM_SRC][$];
   int                   rr_ptr;   // Model of the round-robin pointer

   gmii_tx_top #(.NUM_SRC(NUM_SRC), .QUEUE_DEPTH(QUEUE_DEPTH)) dut_i
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_n_i          (rst_n_i),
      .src_wr_en_i      (src_wr_en_i),
      .src_wr_data_i    (src_wr_data_i),
      .src_send_i       (src_send_i),
      .src_busy_o       (src_busy_o),
      .gmii_txd_o       (gmii_txd_o),
      .gmii_tx_en_o     (gmii_tx_en_o)
   );

   gmii_tx_checker #(.NUM_SRC(NUM_SRC)) chk_i
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_n_i          (rst_n_i),
      .gmii_txd_i       (gmii_txd_o),
      .gmii_tx_en_i     (gmii_tx_en_o),
      .src_busy_i       (src_busy_o)
   );

   initial
   begin
      GMII_GTX_CLK_int = 1'b0;
      forever #5 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;
   end

   // Sources that actually hold bytes when the send arrives
   function automatic logic [NUM_SRC-1:0] active_mask(input int t);
      logic [NUM_SRC-1:0] m;
      for (int i = 0; i < NUM_SRC; i++)
      begin
         m[i] = load_mask[t][i] && (lens[t][i] > 0);
      end
      return m;
   endfunction

   task automatic load_payloads(input int t);
      for (int s = 0; s < NUM_SRC; s++)
      begin
         payload[s].delete();
         for (int k = 0; k < lens[t][s] && load_mask[t][s]; k++)
         begin
            @(negedge GMII_GTX_CLK_int);
            src_wr_en_i   = NUM_SRC'(1) << s;
            src_wr_data_i = gmii_pkg::gmii_byte_t'($urandom);
            payload[s].push_back(src_wr_data_i);
         end
      end
      @(negedge GMII_GTX_CLK_int);
      src_wr_en_i = '0;
   endtask

   task automatic queue_expected(input int t);
      logic [NUM_SRC-1:0] left;
      int                 s;
      left = active_mask(t);
      // Staggered sends let the lowest active source take the idle arbiter
      if (!same_cycle[t])
      begin
         for (int i = NUM_SRC - 1; i >= 0; i--)
         begin
            if (left[i])
               rr_ptr = i;
         end
      end
      while (left != '0)
      begin
         s = rr_ptr;
         while (!left[s])
            s = (s + 1) % NUM_SRC;
         left[s] = 1'b0;
         rr_ptr  = (s + 1) % NUM_SRC;
         chk_i.expect_frame(s, lens[t][s]);
         for (int k = 0; k < payload[s].size(); k++)
            chk_i.expect_byte(payload[s][k]);
      end
   endtask

   task automatic pulse_sends(input int t);
      if (same_cycle[t])
      begin
         @(negedge GMII_GTX_CLK_int);
         src_send_i = load_mask[t];
      end
      else
      begin
         for (int i = 0; i < NUM_SRC; i++)
         begin
            if (load_mask[t][i])
            begin
               @(negedge GMII_GTX_CLK_int);
               src_send_i = NUM_SRC'(1) << i;
            end
         end
      end
      @(negedge GMII_GTX_CLK_int);
      src_send_i = '0;
   endtask

   // Keeps writing junk into busy queues until every frame has left
   task automatic wait_drained();
      logic [NUM_SRC-1:0] busy_seen;
      bit                 idle;
      idle = 1'b0;
      while (!idle)
      begin
         @(negedge GMII_GTX_CLK_int);
         busy_seen     = src_busy_o;
         src_wr_en_i   = busy_seen;
         src_wr_data_i = gmii_pkg::gmii_byte_t'($urandom);
         @(posedge GMII_GTX_CLK_int);
         idle = (busy_seen == '0) && (chk_i.pending_frames() == 0);
      end
   endtask

   initial
   begin
      void'($urandom(86));
      rst_n_i       = 1'b0;
      src_wr_en_i   = '0;
      src_wr_data_i = '0;
      src_send_i    = '0;
      rr_ptr        = 0;
      repeat (16) @(negedge GMII_GTX_CLK_int);
      rst_n_i = 1'b1;
      for (int t = 0; t < NUM_TESTS; t++)
      begin
         chk_i.open_test(test_name[t], active_mask(t));
         load_payloads(t);
         queue_expected(t);
         pulse_sends(t);
         wait_drained();
         chk_i.close_test();
      end
      chk_i.report_counts();
      if ((chk_i.total_errors == 0) && (chk_i.tests_bad == 0))
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   // Watchdog sized from the table, twice the expected cycle count
   initial
   begin
      longint budget;
      int     frames;
      budget = 16;
      for (int t = 0; t < NUM_TESTS; t++)
      begin
         frames = $countones(active_mask(t));
         for (int s = 0; s < NUM_SRC; s++)
            budget += load_mask[t][s] ? lens[t][s] : 0;
         budget += FRAME_OVH * ((frames > 0) ? frames : 1);
      end
      #(budget * 2 * 10);
      $display("Run timed out at %0t, frames did not drain from the DUT", $time);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/gmii_tx_checker.sv
`timescale 1ns/1ns
`default_nettype none

// Rebuilds frames from the GMII pins and compares them with the queued expectation
module gmii_tx_checker
#(
   parameter int NUM_SRC = 2
)
(
   input  logic                 GMII_GTX_CLK_int,
   input  logic                 rst_n_i,
   input  gmii_pkg::gmii_byte_t gmii_txd_i,
   input  logic                 gmii_tx_en_i,
   input  logic [NUM_SRC-1:0]   src_busy_i
);

   gmii_pkg::gmii_byte_t exp_data [$];     // Payload bytes of pending frames
   int                   exp_len  [$];
   int                   exp_src  [$];
   string                test_name = "reset";
   logic [NUM_SRC-1:0]   busy_ok = '0;     // Sources allowed to go busy
   bit                   busy_flagged = 1'b0;
   int                   test_errors = 0;
   int                   total_errors = 0;
   int                   tests_ok = 0;
   int                   tests_bad = 0;
   int                   idx = 0;          // Byte position in the frame on the wire
   int                   low_cnt = 0;      // Idle cycles since the last frame
   bit                   in_frame = 1'b0;
   bit                   seen_frame = 1'b0;
   bit                   stray_frame = 1'b0;

   task automatic log_error(input string msg);
      $display("%s", msg);
      test_errors++;
      total_errors++;
   endtask

   task automatic open_test(input string name, input logic [NUM_SRC-1:0] busy_mask);
      test_name    = name;
      busy_ok      = busy_mask;
      busy_flagged = 1'b0;
      test_errors  = 0;
   endtask

   task automatic expect_frame(input int src, input int len);
      exp_src.push_back(src);
      exp_len.push_back(len);
   endtask

   task automatic expect_byte(input gmii_pkg::gmii_byte_t b);
      exp_data.push_back(b);
   endtask

   function automatic int pending_frames();
      return exp_len.size();
   endfunction

   task automatic close_test();
      if (exp_len.size() != 0)
         log_error($sformatf("%s ended with %0d frames never seen on GMII", test_name,
                             exp_len.size()));
      if (test_errors == 0)
      begin
         tests_ok++;
         $display("%-14s ok", test_name);
      end
      else
      begin
         tests_bad++;
         $display("%-14s FAILED with %0d errors", test_name, test_errors);
      end
   endtask

   task automatic report_counts();
      $display("Summary: %0d tests ok, %0d tests with errors, %0d errors in total",
               tests_ok, tests_bad, total_errors);
   endtask

   task automatic check_byte();
      gmii_pkg::gmii_byte_t want;
      if (idx < gmii_pkg::PREAMBLE_LEN)
         want = gmii_pkg::PREAMBLE_BYTE;
      else if (idx == gmii_pkg::PREAMBLE_LEN)
         want = gmii_pkg::SFD_BYTE;
      else if (idx - gmii_pkg::PREAMBLE_LEN - 1 < exp_len[0])
         want = exp_data.pop_front();
      else
         return;   // Overlong frames are reported at their end
      if (gmii_txd_i != want)
         log_error($sformatf("Error: %s byte %0d expected %02h got %02h", test_name, idx,
                             want, gmii_txd_i));
   endtask

   task automatic finish_frame();
      int used;
      in_frame   = 1'b0;
      seen_frame = 1'b1;
      low_cnt    = 0;
      if (stray_frame)
         return;
      if (idx != exp_len[0] + gmii_pkg::PREAMBLE_LEN + 1)
         log_error($sformatf("Error: %s tx_en cycles expected %0d got %0d", test_name,
                             exp_len[0] + gmii_pkg::PREAMBLE_LEN + 1, idx));
      if (src_busy_i[exp_src[0]])
         log_error($sformatf("Error: %s src_busy_o[%0d] after frame expected 0 got 1",
                             test_name, exp_src[0]));
      // A short frame leaves bytes behind
      used = (idx > gmii_pkg::PREAMBLE_LEN + 1) ? idx - gmii_pkg::PREAMBLE_LEN - 1 : 0;
      for (int k = used; k < exp_len[0]; k++)
         void'(exp_data.pop_front());
      void'(exp_len.pop_front());
      void'(exp_src.pop_front());
   endtask

   always @(negedge GMII_GTX_CLK_int)
   begin
      if (!rst_n_i)
      begin
         if (gmii_tx_en_i || (gmii_txd_i != '0) || (src_busy_i != '0))
            log_error($sformatf("Error: %s tx_en/txd/busy expected 0/00/0 got %b/%02h/%b",
                                test_name, gmii_tx_en_i, gmii_txd_i, src_busy_i));
      end
      else
      begin
         if (((src_busy_i & ~busy_ok) != '0) && !busy_flagged)
         begin
            busy_flagged = 1'b1;
            log_error($sformatf("Error: %s src_busy_o expected %b got %b", test_name,
                                src_busy_i & busy_ok, src_busy_i));
         end
         if (gmii_tx_en_i)
         begin
            if (!in_frame)
            begin
               in_frame    = 1'b1;
               idx         = 0;
               stray_frame = (exp_len.size() == 0);
               if (stray_frame)
                  log_error($sformatf("A frame appeared on GMII in %s with none expected",
                                      test_name));
               else if (!src_busy_i[exp_src[0]])
                  log_error($sformatf("Error: %s src_busy_o[%0d] in frame expected 1 got 0",
                                      test_name, exp_src[0]));
               if (seen_frame && (low_cnt < gmii_pkg::IFG_LEN))
                  log_error($sformatf("Error: %s idle gap expected %0d got %0d", test_name,
                                      gmii_pkg::IFG_LEN, low_cnt));
            end
            if (!stray_frame)
               check_byte();
            idx++;
         end
         else
         begin
            if (in_frame)
               finish_frame();
            low_cnt++;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/gmii_tx_top.sv
`timescale 1ns/1ns
`default_nettype none

module gmii_tx_top
#(
   parameter int NUM_SRC     = 2,
   parameter int QUEUE_DEPTH = 64
)
(
   input  logic                 GMII_GTX_CLK_int,
   input  logic                 rst_n_i,
   input  logic [NUM_SRC-1:0]   src_wr_en_i,
   input  gmii_pkg::gmii_byte_t src_wr_data_i,   // Shared by all queues
   input  logic [NUM_SRC-1:0]   src_send_i,
   output logic [NUM_SRC-1:0]   src_busy_o,
   output gmii_pkg::gmii_byte_t gmii_txd_o,
   output logic                 gmii_tx_en_o
);

   tx_frame_if src_if [NUM_SRC] ();
   tx_frame_if sel_if ();   // Granted stream toward the framer

   for (genvar i = 0; i < NUM_SRC; i++)
   begin : g_queue
      frame_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_i
      (
         .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
         .rst_n_i          (rst_n_i),
         .wr_en_i          (src_wr_en_i[i]),
         .wr_data_i        (src_wr_data_i),
         .send_i           (src_send_i[i]),
         .busy_o           (src_busy_o[i]),
         .frame_o          (src_if[i])
      );
   end

   tx_arbiter #(.NUM_SRC(NUM_SRC)) arb_i
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_n_i          (rst_n_i),
      .src_o            (src_if),
      .sel_o            (sel_if)
   );

   gmii_tx_framer framer_i
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_n_i          (rst_n_i),
      .frame_i          (sel_if),
      .gmii_txd_o       (gmii_txd_o),
      .gmii_tx_en_o     (gmii_tx_en_o)
   );

endmodule

`default_nettype wire

//--- source/gmii_tx_framer.sv
`timescale 1ns/1ns
`default_nettype none

module gmii_tx_framer
(
   input  logic                 GMII_GTX_CLK_int,
   input  logic                 rst_n_i,
   tx_frame_if.framer           frame_i,
   output gmii_pkg::gmii_byte_t gmii_txd_o,
   output logic                 gmii_tx_en_o
);

   gmii_pkg::tx_state_t  state_q;
   logic [3:0]           cnt_q;     // Preamble and gap counter
   gmii_pkg::gmii_byte_t txd_d;
   logic                 tx_en_d;

   // Granted queue holds the whole frame, so no stalls here
   assign frame_i.pop = (state_q == gmii_pkg::PAYLOAD) && frame_i.req;

   always_ff @(posedge GMII_GTX_CLK_int or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q <= gmii_pkg::IDLE;
         cnt_q   <= '0;
      end
      else
      begin
         case (state_q)
            gmii_pkg::IDLE:
            begin
               cnt_q <= '0;
               if (frame_i.req)
               begin
                  state_q <= gmii_pkg::PREAMBLE;
               end
            end
            gmii_pkg::PREAMBLE:
            begin
               if (cnt_q == 4'(gmii_pkg::PREAMBLE_LEN - 1))
               begin
                  state_q <= gmii_pkg::SFD;
                  cnt_q   <= '0;
               end
               else
               begin
                  cnt_q <= cnt_q + 4'd1;
               end
            end
            gmii_pkg::SFD: state_q <= gmii_pkg::PAYLOAD;
            gmii_pkg::PAYLOAD:
            begin
               if (frame_i.pop && frame_i.last)
               begin
                  state_q <= gmii_pkg::GAP;
                  cnt_q   <= '0;
               end
            end
            gmii_pkg::GAP:
            begin
               if (cnt_q == 4'(gmii_pkg::IFG_LEN - 1))   // Inter-frame gap done
               begin
                  state_q <= gmii_pkg::IDLE;
               end
               else
               begin
                  cnt_q <= cnt_q + 4'd1;
               end
            end
            default: state_q <= gmii_pkg::IDLE;
         endcase
      end
   end

   always_comb
   begin
      tx_en_d = 1'b1;
      case (state_q)
         gmii_pkg::PREAMBLE: txd_d = gmii_pkg::PREAMBLE_BYTE;
         gmii_pkg::SFD:      txd_d = gmii_pkg::SFD_BYTE;
         gmii_pkg::PAYLOAD:  txd_d = frame_i.data;
         default:
         begin
            txd_d   = '0;
            tx_en_d = 1'b0;
         end
      endcase
   end

   // GMII output flops
   always_ff @(posedge GMII_GTX_CLK_int or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         gmii_txd_o   <= '0;
         gmii_tx_en_o <= 1'b0;
      end
      else
      begin
         gmii_txd_o   <= txd_d;
         gmii_tx_en_o <= tx_en_d;
      end
   end

   // Payload bytes flow without gaps
   a_no_stall: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
      (state_q == gmii_pkg::PAYLOAD) |-> frame_i.req);

endmodule

`default_nettype wire

//--- source/tx_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module tx_arbiter
#(
   parameter int NUM_SRC = 2
)
(
   input  logic       GMII_GTX_CLK_int,
   input  logic       rst_n_i,
   tx_frame_if.arb    src_o [NUM_SRC],
   tx_frame_if.queue  sel_o
);

   localparam int PTR_W = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;

   typedef logic [PTR_W-1:0] src_idx_t;

   logic [NUM_SRC-1:0]   req_v;
   logic [NUM_SRC-1:0]   last_v;
   gmii_pkg::gmii_byte_t data_v [NUM_SRC];
   logic [NUM_SRC-1:0]   gnt_q;     // One-hot grant
   src_idx_t             win_q;     // Index of the granted source
   src_idx_t             ptr_q;     // Round-robin start point
   src_idx_t             pick;
   logic                 found;
   logic                 done;

   for (genvar i = 0; i < NUM_SRC; i++)
   begin : g_src
      assign req_v[i]     = src_o[i].req;
      assign last_v[i]    = src_o[i].last;
      assign data_v[i]    = src_o[i].data;
      assign src_o[i].gnt = gnt_q[i];
      assign src_o[i].pop = gnt_q[i] && sel_o.pop;   // Pop only to the winner
   end

   // First requester at or after the pointer
   always_comb
   begin
      int idx;
      found = 1'b0;
      pick  = '0;
      for (int k = 0; k < NUM_SRC; k++)
      begin
         idx = (int'(ptr_q) + k) % NUM_SRC;
         if (!found && req_v[idx])
         begin
            found = 1'b1;
            pick  = src_idx_t'(idx);
         end
      end
   end

   assign done = (|gnt_q) && sel_o.pop && sel_o.last;

   always_ff @(posedge GMII_GTX_CLK_int or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         gnt_q <= '0;
         win_q <= '0;
         ptr_q <= '0;
      end
      else if (done)
      begin
         gnt_q <= '0;
         ptr_q <= (win_q == src_idx_t'(NUM_SRC - 1)) ? '0 : win_q + src_idx_t'(1);
      end
      else if (!(|gnt_q) && found)   // Framer idle and a requester found
      begin
         gnt_q <= NUM_SRC'(1) << pick;
         win_q <= pick;
      end
   end

   assign sel_o.req  = |(req_v & gnt_q);
   assign sel_o.last = (|gnt_q) && last_v[win_q];
   assign sel_o.data = data_v[win_q];

   // Granted source keeps requesting until its last pop
   a_gnt_requesting: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
      (|gnt_q) |-> (|(gnt_q & req_v)));

endmodule

`default_nettype wire

//--- frame_queue/frame_queue.sv
`timescale 1ns/1ns
`default_nettype none

module frame_queue
#(
   parameter int QUEUE_DEPTH = 64
)
(
   input  logic                 GMII_GTX_CLK_int,
   input  logic                 rst_n_i,
   input  logic                 wr_en_i,
   input  gmii_pkg::gmii_byte_t wr_data_i,
   input  logic                 send_i,
   output logic                 busy_o,
   tx_frame_if.queue            frame_o
);

   localparam int AW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

   gmii_pkg::gmii_byte_t mem [QUEUE_DEPTH];
   gmii_pkg::frame_len_t len_q;      // Bytes written so far
   gmii_pkg::frame_len_t rd_ptr_q;
   gmii_pkg::frame_len_t last_idx;
   logic                 busy_q;     // Frame locked and requesting
   logic                 wr_ok;
   logic                 last_pop;

   // Writes land only while the frame is still open
   assign wr_ok    = wr_en_i && !busy_q && (len_q < QUEUE_DEPTH);
   assign last_idx = len_q - gmii_pkg::frame_len_t'(1);
   assign last_pop = frame_o.pop && frame_o.last;

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (wr_ok)
      begin
         mem[len_q[AW-1:0]] <= wr_data_i;
      end
   end

   always_ff @(posedge GMII_GTX_CLK_int or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         len_q    <= '0;
         rd_ptr_q <= '0;
         busy_q   <= 1'b0;
      end
      else if (busy_q)
      begin
         if (last_pop)
         begin
            // Frame gone, reopen for the next one
            len_q    <= '0;
            rd_ptr_q <= '0;
            busy_q   <= 1'b0;
         end
         else if (frame_o.pop)
         begin
            rd_ptr_q <= rd_ptr_q + gmii_pkg::frame_len_t'(1);
         end
      end
      else
      begin
         if (wr_ok)
         begin
            len_q <= len_q + gmii_pkg::frame_len_t'(1);
         end
         if (send_i && (len_q != '0))   // Empty send is dropped
         begin
            busy_q <= 1'b1;
         end
      end
   end

   assign busy_o       = busy_q;
   assign frame_o.req  = busy_q;
   assign frame_o.data = mem[rd_ptr_q[AW-1:0]];
   assign frame_o.last = busy_q && (rd_ptr_q == last_idx);

   // Pops only come from the granted, requesting queue
   a_pop_granted: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
      frame_o.pop |-> (frame_o.req && frame_o.gnt));

   a_no_overflow: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
      (wr_en_i && !busy_q) |-> (len_q < QUEUE_DEPTH));

endmodule

`default_nettype wire

//--- common/tx_frame_if.sv
`timescale 1ns/1ns
`default_nettype none

// One queue's frame stream toward the arbiter and framer
interface tx_frame_if;

   logic                 req;    // Released frame waiting
   logic                 gnt;    // Arbiter grant
   gmii_pkg::gmii_byte_t data;   // Byte at the read pointer
   logic                 last;   // Final byte of the frame
   logic                 pop;    // Byte consumed this cycle

   modport queue
   (
      output req,
      output data,
      output last,
      input  gnt,
      input  pop
   );

   modport arb
   (
      input  req,
      input  data,
      input  last,
      output gnt,
      output pop
   );

   modport framer
   (
      input  req,
      input  data,
      input  last,
      output pop
   );

endinterface

`default_nettype wire

//--- common/gmii_pkg.sv
`default_nettype none

package gmii_pkg;

   typedef logic [7:0] gmii_byte_t;   // One GMII data byte
   typedef logic [6:0] frame_len_t;   // Payload length, up to 64 bytes

   // Framer states
   typedef enum logic [2:0]
   {
      IDLE,
      PREAMBLE,
      SFD,
      PAYLOAD,
      GAP
   } tx_state_t;

   // Framing constants
   localparam gmii_byte_t PREAMBLE_BYTE = 8'h55;
   localparam gmii_byte_t SFD_BYTE      = 8'hD5;
   localparam int         PREAMBLE_LEN  = 7;
   localparam int         IFG_LEN       = 12;   // Idle cycles after each frame

endpackage

`default_nettype wire
